// ==== src/cpu_bus_pkg.sv ====
// main cpu bus definitions
`default_nettype none

package cpu_bus_pkg;

    typedef logic [15:0] cpu_word_t;
    typedef logic [22:0] cpu_addr_t;   // byte address >> 1
    typedef logic [23:0] byte_addr_t;  // full 68k byte address
    typedef logic [1:0]  byte_sel_t;   // [1] upper lane, [0] lower lane
    typedef logic [7:0]  sound_byte_t;

    typedef enum logic {
        PHASE_IDLE,
        PHASE_ACK
    } bus_phase_e;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_SOUND_RAM,
        REGION_IO,
        REGION_PALETTE,
        REGION_TEXT
    } region_e;

    // memory map, byte addresses
    localparam byte_addr_t SOUND_RAM_BASE = 24'h218000;
    localparam byte_addr_t SOUND_RAM_SIZE = 24'h004000;
    localparam byte_addr_t IO_BASE        = 24'h21C000;
    localparam byte_addr_t IO_SIZE        = 24'h001000;
    localparam byte_addr_t VDP_BASE       = 24'h300000;
    localparam byte_addr_t VDP_SIZE       = 24'h000010;  // registers 0x0..0xD
    localparam byte_addr_t PALETTE_BASE   = 24'h400000;
    localparam byte_addr_t PALETTE_SIZE   = 24'h001000;
    localparam byte_addr_t TEXT_BASE      = 24'h500000;
    localparam byte_addr_t TEXT_SIZE      = 24'h002000;
    localparam byte_addr_t LATCH_BASE     = 24'h600000;
    localparam byte_addr_t LATCH_SIZE     = 24'h000010;

    // byte offsets inside IO_BASE
    localparam logic [11:0] PORT_P1     = 12'h020;
    localparam logic [11:0] PORT_P2     = 12'h024;
    localparam logic [11:0] PORT_SYS    = 12'h028;
    localparam logic [11:0] PORT_DSWA   = 12'h02C;
    localparam logic [11:0] PORT_DSWB   = 12'h030;
    localparam logic [11:0] PORT_VCOUNT = 12'h03C;

    // true when a word address falls inside [base, base+size)
    function automatic logic in_range(cpu_addr_t adr, byte_addr_t base, byte_addr_t size);
        byte_addr_t byte_adr;
        byte_adr = {adr, 1'b0};
        return (byte_adr >= base) && (byte_adr < base + size);
    endfunction

endpackage

`default_nettype wire

// ==== src/cpu_bus_if.sv ====
// decoded cpu access
`default_nettype none
`timescale 1ns/1ps

interface cpu_bus_if;
    import cpu_bus_pkg::*;

    logic      stb;    // single cycle, start of access
    logic      we;
    byte_sel_t sel;
    cpu_addr_t addr;   // region word offset, full address on io
    cpu_word_t wdata;
    cpu_word_t rdata;  // valid during the ack cycle

    modport host (output stb, we, sel, addr, wdata, input rdata);
    modport target (input stb, we, sel, addr, wdata, output rdata);

endinterface

`default_nettype wire

// ==== src/main_bus_decoder.sv ====
// wishbone front end and region decode
`default_nettype none
`timescale 1ns/1ps

module main_bus_decoder (
    input  wire                    CLK96,
    input  wire                    RESET96,
    input  wire                    wb_cyc,
    input  wire                    wb_stb,
    input  wire                    wb_we,
    input  wire cpu_bus_pkg::cpu_addr_t wb_adr,
    input  wire cpu_bus_pkg::byte_sel_t wb_sel,
    input  wire cpu_bus_pkg::cpu_word_t wb_dat_w,
    output cpu_bus_pkg::cpu_word_t wb_dat_r,
    output logic                   wb_ack,
    cpu_bus_if.host                bus_sound,
    cpu_bus_if.host                bus_io,
    cpu_bus_if.host                bus_palette,
    cpu_bus_if.host                bus_text
);
    import cpu_bus_pkg::*;

    bus_phase_e phase;
    region_e    region_d;
    region_e    region_q;  // held through the ack cycle
    logic       start;

    assign start = wb_cyc && wb_stb && (phase == PHASE_IDLE);

    always_comb begin
        region_d = REGION_NONE;
        if (in_range(wb_adr, SOUND_RAM_BASE, SOUND_RAM_SIZE)) begin
            region_d = REGION_SOUND_RAM;
        end else if (in_range(wb_adr, IO_BASE, IO_SIZE) ||
                     in_range(wb_adr, VDP_BASE, VDP_SIZE) ||
                     in_range(wb_adr, LATCH_BASE, LATCH_SIZE)) begin
            region_d = REGION_IO;  // io_ports sorts these out itself
        end else if (in_range(wb_adr, PALETTE_BASE, PALETTE_SIZE)) begin
            region_d = REGION_PALETTE;
        end else if (in_range(wb_adr, TEXT_BASE, TEXT_SIZE)) begin
            region_d = REGION_TEXT;
        end
    end

    assign bus_sound.stb   = start && (region_d == REGION_SOUND_RAM);
    assign bus_sound.we    = wb_we;
    assign bus_sound.sel   = wb_sel;
    assign bus_sound.addr  = wb_adr - SOUND_RAM_BASE[23:1];
    assign bus_sound.wdata = wb_dat_w;

    assign bus_io.stb   = start && (region_d == REGION_IO);
    assign bus_io.we    = wb_we;
    assign bus_io.sel   = wb_sel;
    assign bus_io.addr  = wb_adr;  // full address, three ranges behind it
    assign bus_io.wdata = wb_dat_w;

    assign bus_palette.stb   = start && (region_d == REGION_PALETTE);
    assign bus_palette.we    = wb_we;
    assign bus_palette.sel   = wb_sel;
    assign bus_palette.addr  = wb_adr - PALETTE_BASE[23:1];
    assign bus_palette.wdata = wb_dat_w;

    assign bus_text.stb   = start && (region_d == REGION_TEXT);
    assign bus_text.we    = wb_we;
    assign bus_text.sel   = wb_sel;
    assign bus_text.addr  = wb_adr - TEXT_BASE[23:1];
    assign bus_text.wdata = wb_dat_w;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            phase    <= PHASE_IDLE;
            region_q <= REGION_NONE;
        end else begin
            case (phase)
                PHASE_IDLE: begin
                    if (start) begin
                        phase    <= PHASE_ACK;
                        region_q <= region_d;
                    end
                end
                PHASE_ACK: phase <= PHASE_IDLE;  // fixed one cycle latency
                default:   phase <= PHASE_IDLE;
            endcase
        end
    end

    assign wb_ack = (phase == PHASE_ACK);

    always_comb begin
        case (region_q)
            REGION_SOUND_RAM: wb_dat_r = {8'h00, bus_sound.rdata[7:0]};
            REGION_IO:        wb_dat_r = bus_io.rdata;
            REGION_PALETTE:   wb_dat_r = bus_palette.rdata;
            REGION_TEXT:      wb_dat_r = bus_text.rdata;
            default:          wb_dat_r = '0;  // unmapped reads zero
        endcase
    end

endmodule

`default_nettype wire

// ==== src/video_dual_ram.sv ====
// cpu and video dual port word ram
`default_nettype none
`timescale 1ns/1ps

module video_dual_ram #(
    parameter int ADDR_W = 11
) (
    input  wire                    CLK96,
    cpu_bus_if.target              bus,
    input  wire [ADDR_W-1:0]       vaddr,
    output cpu_bus_pkg::cpu_word_t vdata
);
    import cpu_bus_pkg::*;

    cpu_word_t         mem [2**ADDR_W];
    logic [ADDR_W-1:0] cpu_a;
    logic              wr;

    assign cpu_a = bus.addr[ADDR_W-1:0];
    assign wr    = bus.stb && bus.we;

    // cpu port, lane writes
    always_ff @(posedge CLK96) begin
        if (wr && bus.sel[1]) begin
            mem[cpu_a][15:8] <= bus.wdata[15:8];
        end
        if (wr && bus.sel[0]) begin
            mem[cpu_a][7:0] <= bus.wdata[7:0];
        end
        if (bus.stb) begin
            bus.rdata <= mem[cpu_a];  // ready for the ack cycle
        end
    end

    // video side, read only
    always_ff @(posedge CLK96) begin
        vdata <= mem[vaddr];
    end

endmodule

`default_nettype wire

// ==== src/sound_shared_ram.sv ====
// shared ram between main and sound cpu
`default_nettype none
`timescale 1ns/1ps

module sound_shared_ram #(
    parameter int ADDR_W = 14
) (
    input  wire                      CLK96,
    cpu_bus_if.target                bus,
    input  wire [ADDR_W-1:0]         snd_addr,
    input  wire cpu_bus_pkg::sound_byte_t snd_din,
    input  wire                      snd_we,
    output cpu_bus_pkg::sound_byte_t snd_dout
);
    import cpu_bus_pkg::*;

    sound_byte_t       mem [2**ADDR_W];
    logic [ADDR_W-1:0] cpu_a;

    assign cpu_a = bus.addr[ADDR_W-1:0];

    always_ff @(posedge CLK96) begin
        // main cpu only drives the low lane
        if (bus.stb && bus.we && bus.sel[0]) begin
            mem[cpu_a] <= bus.wdata[7:0];
        end
        if (snd_we) begin
            mem[snd_addr] <= snd_din;  // sound cpu port
        end
        if (bus.stb) begin
            bus.rdata <= {8'h00, mem[cpu_a]};
        end
        snd_dout <= mem[snd_addr];
    end

endmodule

`default_nettype wire

// ==== src/io_ports.sv ====
// io ports, sound latch and vdp strobes
`default_nettype none
`timescale 1ns/1ps

module io_ports (
    input  wire                    CLK96,
    input  wire                    RESET96,
    cpu_bus_if.target              bus,
    input  wire [8:0]              vcount,
    input  wire                    hsync,
    input  wire                    vsync,
    input  wire                    fblank,
    input  wire [7:0]              joy1,
    input  wire [7:0]              joy2,
    input  wire [1:0]              start,
    input  wire [1:0]              coin,
    input  wire                    service,
    input  wire                    dip_test,
    input  wire [7:0]              dipsw_a,
    input  wire [7:0]              dipsw_b,
    input  wire [7:0]              dipsw_c,
    input  wire cpu_bus_pkg::cpu_word_t vdp_dout,
    input  wire                    vdp_ack,
    output logic                   op_select_reg,
    output logic                   op_write_reg,
    output logic                   op_write_ram,
    output logic                   op_read_ram_h,
    output logic                   op_read_ram_l,
    output logic                   op_set_ram_ptr,
    output cpu_bus_pkg::sound_byte_t sound_latch,
    output logic                   sound_int
);
    import cpu_bus_pkg::*;

    byte_addr_t  byte_adr;
    logic [11:0] io_off;
    logic [3:0]  vdp_off;
    logic        in_io;
    logic        in_vdp;
    logic        in_latch;
    logic        vdp_start;
    logic        latch_wr;
    cpu_word_t   video_status;
    cpu_word_t   rd_mux;

    assign byte_adr = {bus.addr, 1'b0};
    assign io_off   = byte_adr[11:0];
    assign vdp_off  = byte_adr[3:0];

    assign in_io    = in_range(bus.addr, IO_BASE, IO_SIZE);
    assign in_vdp   = in_range(bus.addr, VDP_BASE, VDP_SIZE);
    assign in_latch = in_range(bus.addr, LATCH_BASE, LATCH_SIZE);

    assign vdp_start = bus.stb && in_vdp;
    assign latch_wr  = bus.stb && bus.we && in_latch;

    // sync flags on top, line count saturates past 255
    assign video_status = {hsync, vsync, 5'b11111, fblank,
                           vcount[8] ? 8'hFF : vcount[7:0]};

    always_comb begin
        rd_mux = '0;
        if (in_io) begin
            case (io_off)
                PORT_P1:     rd_mux = {2{~joy1}};  // board inputs are active low
                PORT_P2:     rd_mux = {2{~joy2}};
                PORT_SYS:    rd_mux = {dipsw_c, 1'b0, ~start[1], ~start[0], ~coin[1],
                                       ~coin[0], ~dip_test, 1'b0, ~service};
                PORT_DSWA:   rd_mux = {2{dipsw_a}};
                PORT_DSWB:   rd_mux = {2{dipsw_b}};
                PORT_VCOUNT: rd_mux = video_status;
                default:     rd_mux = '0;
            endcase
        end else if (in_vdp) begin
            rd_mux = vdp_dout;
        end
    end

    always_ff @(posedge CLK96) begin
        if (bus.stb) begin
            bus.rdata <= rd_mux;
        end
    end

    always_ff @(posedge CLK96) begin
        if (latch_wr) begin
            sound_latch <= bus.wdata[7:0];
        end
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            sound_int <= 1'b0;
        end else begin
            sound_int <= latch_wr;  // one cycle per latch write
        end
    end

    // command strobes hold until the vdp acknowledges
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            op_select_reg  <= 1'b0;
            op_write_reg   <= 1'b0;
            op_write_ram   <= 1'b0;
            op_read_ram_h  <= 1'b0;
            op_read_ram_l  <= 1'b0;
            op_set_ram_ptr <= 1'b0;
        end else if (vdp_start) begin
            if (bus.we) begin
                case (vdp_off)
                    4'h0:       op_set_ram_ptr <= 1'b1;
                    4'h4, 4'h6: op_write_ram   <= 1'b1;
                    4'h8:       op_select_reg  <= 1'b1;
                    4'hC:       op_write_reg   <= 1'b1;
                    default:    ;
                endcase
            end else begin
                case (vdp_off)
                    4'h4:    op_read_ram_h <= 1'b1;
                    4'h6:    op_read_ram_l <= 1'b1;
                    default: ;
                endcase
            end
        end else if (vdp_ack) begin
            op_select_reg  <= 1'b0;
            op_write_reg   <= 1'b0;
            op_write_ram   <= 1'b0;
            op_read_ram_h  <= 1'b0;
            op_read_ram_l  <= 1'b0;
            op_set_ram_ptr <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_bus_top.sv ====
// main cpu bus glue
`default_nettype none
`timescale 1ns/1ps

module cpu_bus_top #(
    parameter int PAL_ADDR_W   = 11,
    parameter int TEXT_ADDR_W  = 12,
    parameter int SOUND_ADDR_W = 14
) (
    input  wire                      CLK96,
    input  wire                      RESET96,
    // wishbone slave
    input  wire                      wb_cyc,
    input  wire                      wb_stb,
    input  wire                      wb_we,
    input  wire cpu_bus_pkg::cpu_addr_t wb_adr,
    input  wire cpu_bus_pkg::byte_sel_t wb_sel,
    input  wire cpu_bus_pkg::cpu_word_t wb_dat_w,
    output cpu_bus_pkg::cpu_word_t   wb_dat_r,
    output logic                     wb_ack,
    // video read side
    input  wire [PAL_ADDR_W-1:0]     pal_vaddr,
    output cpu_bus_pkg::cpu_word_t   pal_vdata,
    input  wire [TEXT_ADDR_W-1:0]    text_vaddr,
    output cpu_bus_pkg::cpu_word_t   text_vdata,
    // sound cpu side
    input  wire [SOUND_ADDR_W-1:0]   snd_addr,
    input  wire cpu_bus_pkg::sound_byte_t snd_din,
    input  wire                      snd_we,
    output cpu_bus_pkg::sound_byte_t snd_dout,
    input  wire [8:0]                vcount,
    input  wire                      hsync,
    input  wire                      vsync,
    input  wire                      fblank,
    input  wire [7:0]                joy1,
    input  wire [7:0]                joy2,
    input  wire [1:0]                start,
    input  wire [1:0]                coin,
    input  wire                      service,
    input  wire                      dip_test,
    input  wire [7:0]                dipsw_a,
    input  wire [7:0]                dipsw_b,
    input  wire [7:0]                dipsw_c,
    // video chip
    input  wire cpu_bus_pkg::cpu_word_t vdp_dout,
    input  wire                      vdp_ack,
    output logic                     op_select_reg,
    output logic                     op_write_reg,
    output logic                     op_write_ram,
    output logic                     op_read_ram_h,
    output logic                     op_read_ram_l,
    output logic                     op_set_ram_ptr,
    output cpu_bus_pkg::sound_byte_t sound_latch,
    output logic                     sound_int
);

    cpu_bus_if bus_sound ();
    cpu_bus_if bus_io ();
    cpu_bus_if bus_palette ();
    cpu_bus_if bus_text ();

    main_bus_decoder u_decoder (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_sel      (wb_sel),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .bus_sound   (bus_sound),
        .bus_io      (bus_io),
        .bus_palette (bus_palette),
        .bus_text    (bus_text)
    );

    video_dual_ram #(.ADDR_W(PAL_ADDR_W)) u_palette (
        .CLK96 (CLK96),
        .bus   (bus_palette),
        .vaddr (pal_vaddr),
        .vdata (pal_vdata)
    );

    video_dual_ram #(.ADDR_W(TEXT_ADDR_W)) u_text (
        .CLK96 (CLK96),
        .bus   (bus_text),
        .vaddr (text_vaddr),
        .vdata (text_vdata)
    );

    sound_shared_ram #(.ADDR_W(SOUND_ADDR_W)) u_sound_ram (
        .CLK96    (CLK96),
        .bus      (bus_sound),
        .snd_addr (snd_addr),
        .snd_din  (snd_din),
        .snd_we   (snd_we),
        .snd_dout (snd_dout)
    );

    io_ports u_io (
        .CLK96          (CLK96),
        .RESET96        (RESET96),
        .bus            (bus_io),
        .vcount         (vcount),
        .hsync          (hsync),
        .vsync          (vsync),
        .fblank         (fblank),
        .joy1           (joy1),
        .joy2           (joy2),
        .start          (start),
        .coin           (coin),
        .service        (service),
        .dip_test       (dip_test),
        .dipsw_a        (dipsw_a),
        .dipsw_b        (dipsw_b),
        .dipsw_c        (dipsw_c),
        .vdp_dout       (vdp_dout),
        .vdp_ack        (vdp_ack),
        .op_select_reg  (op_select_reg),
        .op_write_reg   (op_write_reg),
        .op_write_ram   (op_write_ram),
        .op_read_ram_h  (op_read_ram_h),
        .op_read_ram_l  (op_read_ram_l),
        .op_set_ram_ptr (op_set_ram_ptr),
        .sound_latch    (sound_latch),
        .sound_int      (sound_int)
    );

endmodule

`default_nettype wire

// ==== tests/tb_cpu_bus.sv ====
// cpu bus glue testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_bus;
    import cpu_bus_pkg::*;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 10;
    localparam int PAL_ADDR_W   = 11;
    localparam int TEXT_ADDR_W  = 12;
    localparam int SOUND_ADDR_W = 14;

    logic CLK96;
    logic RESET96;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    cpu_addr_t wb_adr;
    byte_sel_t wb_sel;
    cpu_word_t wb_dat_w;
    cpu_word_t wb_dat_r;
    logic wb_ack;
    logic [PAL_ADDR_W-1:0] pal_vaddr;
    cpu_word_t pal_vdata;
    logic [TEXT_ADDR_W-1:0] text_vaddr;
    cpu_word_t text_vdata;
    logic [SOUND_ADDR_W-1:0] snd_addr;
    sound_byte_t snd_din;
    logic snd_we;
    sound_byte_t snd_dout;
    logic [8:0] vcount;
    logic hsync;
    logic vsync;
    logic fblank;
    logic [7:0] joy1;
    logic [7:0] joy2;
    logic [1:0] start;
    logic [1:0] coin;
    logic service;
    logic dip_test;
    logic [7:0] dipsw_a;
    logic [7:0] dipsw_b;
    logic [7:0] dipsw_c;
    cpu_word_t vdp_dout;
    logic vdp_ack;
    logic op_select_reg;
    logic op_write_reg;
    logic op_write_ram;
    logic op_read_ram_h;
    logic op_read_ram_l;
    logic op_set_ram_ptr;
    sound_byte_t sound_latch;
    logic sound_int;

    logic [5:0] strobes;
    assign strobes = {op_select_reg, op_write_reg, op_write_ram,
                      op_read_ram_h, op_read_ram_l, op_set_ram_ptr};

    // case table filled from the cases file
    string      case_op[$];
    byte_addr_t case_addr[$];
    byte_sel_t  case_sel[$];
    cpu_word_t  case_data[$];
    cpu_word_t  case_exp[$];
    int         case_count = 0;
    logic       cases_ready = 1'b0;
    int         latch_pulses = 0;
    logic [31:0] lcg_state = 32'd41;

    cpu_bus_top #(
        .PAL_ADDR_W   (PAL_ADDR_W),
        .TEXT_ADDR_W  (TEXT_ADDR_W),
        .SOUND_ADDR_W (SOUND_ADDR_W)
    ) uut (
        .CLK96 (CLK96), .RESET96 (RESET96),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_sel (wb_sel), .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack),
        .pal_vaddr (pal_vaddr), .pal_vdata (pal_vdata),
        .text_vaddr (text_vaddr), .text_vdata (text_vdata),
        .snd_addr (snd_addr), .snd_din (snd_din), .snd_we (snd_we), .snd_dout (snd_dout),
        .vcount (vcount), .hsync (hsync), .vsync (vsync), .fblank (fblank),
        .joy1 (joy1), .joy2 (joy2), .start (start), .coin (coin),
        .service (service), .dip_test (dip_test),
        .dipsw_a (dipsw_a), .dipsw_b (dipsw_b), .dipsw_c (dipsw_c),
        .vdp_dout (vdp_dout), .vdp_ack (vdp_ack),
        .op_select_reg (op_select_reg), .op_write_reg (op_write_reg),
        .op_write_ram (op_write_ram), .op_read_ram_h (op_read_ram_h),
        .op_read_ram_l (op_read_ram_l), .op_set_ram_ptr (op_set_ram_ptr),
        .sound_latch (sound_latch), .sound_int (sound_int)
    );

    initial CLK96 = 1'b0;
    always #(CLK_PERIOD / 2) CLK96 = ~CLK96;

    // sound_int high cycles
    always @(negedge CLK96) begin
        if (sound_int) latch_pulses++;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Some tests failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input cpu_word_t expected, input cpu_word_t actual,
                              input string what);
        if (actual !== expected)
            abort_run($sformatf("error: at %0d ns: %s expected %h got %h",
                                $time, what, expected, actual));
    endtask

    task automatic check_byte(input sound_byte_t expected, input sound_byte_t actual,
                              input string what);
        if (actual !== expected)
            abort_run($sformatf("error: at %0d ns: %s expected %h got %h",
                                $time, what, expected, actual));
    endtask

    task automatic check_strobe(input logic [5:0] expected, input logic [5:0] actual,
                                input string what);
        if (actual !== expected)
            abort_run($sformatf("error: at %0d ns: %s expected %b got %b",
                                $time, what, expected, actual));
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic is_vdp(input byte_addr_t a);
        return (a >= VDP_BASE) && (a < VDP_BASE + VDP_SIZE);
    endfunction

    function automatic logic is_latch(input byte_addr_t a);
        return (a >= LATCH_BASE) && (a < LATCH_BASE + LATCH_SIZE);
    endfunction

    // expected port read from the board's port layout
    function automatic cpu_word_t port_value(input byte_addr_t a);
        cpu_word_t v;
        logic [11:0] off;
        v = 16'h0000;
        off = a[11:0];
        if ((a >= IO_BASE) && (a < IO_BASE + IO_SIZE)) begin
            if (off == PORT_P1) v = {~joy1, ~joy1};
            if (off == PORT_P2) v = {~joy2, ~joy2};
            if (off == PORT_SYS) begin
                v[15:8] = dipsw_c;
                v[7:0]  = {1'b0, ~start[1], ~start[0], ~coin[1], ~coin[0],
                           ~dip_test, 1'b0, ~service};
            end
            if (off == PORT_DSWA) v = {dipsw_a, dipsw_a};
            if (off == PORT_DSWB) v = {dipsw_b, dipsw_b};
            if (off == PORT_VCOUNT) begin
                v = 16'hFFFF;
                v[15] = hsync;
                v[14] = vsync;
                v[8]  = fblank;
                if (vcount < 9'd256) v[7:0] = vcount[7:0];
            end
        end else if (is_vdp(a)) begin
            v = vdp_dout;
        end
        return v;
    endfunction

    // {select_reg, write_reg, write_ram, read_ram_h, read_ram_l, set_ram_ptr}
    function automatic logic [5:0] expected_strobes(input byte_addr_t a, input logic we);
        logic [5:0] m;
        logic [3:0] off;
        m = 6'b0;
        off = a[3:0];
        if (we) begin
            if (off == 4'h0) m[0] = 1'b1;
            if (off == 4'h4 || off == 4'h6) m[3] = 1'b1;
            if (off == 4'h8) m[5] = 1'b1;
            if (off == 4'hC) m[4] = 1'b1;
        end else begin
            if (off == 4'h4) m[2] = 1'b1;
            if (off == 4'h6) m[1] = 1'b1;
        end
        return m;
    endfunction

    task automatic load_cases();
        int fd;
        int n;
        string line;
        string op;
        logic [31:0] a, s, d, e;
        fd = $fopen("tests/bus_cases.txt", "r");
        if (fd == 0) abort_run("could not open tests/bus_cases.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") continue;
            n = $sscanf(line, "%s %h %h %h %h", op, a, s, d, e);
            if (n != 5) abort_run({"malformed line in cases file: ", line});
            case_op.push_back(op);
            case_addr.push_back(a[23:0]);
            case_sel.push_back(s[1:0]);
            case_data.push_back(d[15:0]);
            case_exp.push_back(e[15:0]);
        end
        $fclose(fd);
        case_count = case_op.size();
        cases_ready = 1'b1;
    endtask

    task automatic draw_inputs();
        logic [31:0] r;
        r = next_rand();
        joy1 = r[23:16];
        joy2 = r[31:24];
        r = next_rand();
        dipsw_a = r[23:16];
        dipsw_b = r[31:24];
        r = next_rand();
        dipsw_c = r[23:16];
        coin = r[25:24];
        start = r[27:26];
        service = r[28];
        dip_test = r[29];
        r = next_rand();
        vdp_dout = r[31:16];
        vcount = r[24:16];
    endtask

    // one wishbone cycle with ack right after the start edge
    task automatic bus_access(input logic we, input byte_addr_t a, input byte_sel_t sel,
                              input cpu_word_t wdata, output cpu_word_t rdata);
        int waited;
        @(negedge CLK96);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = a[23:1];
        wb_sel = sel;
        wb_dat_w = wdata;
        @(posedge CLK96);  // start edge
        waited = 0;
        do begin
            @(negedge CLK96);
            waited++;
        end while (!wb_ack && waited < 4);
        if (!wb_ack) abort_run($sformatf("no ack within 4 cycles for address %h", a));
        if (waited != 1)
            abort_run($sformatf("error: at %0d ns: ack latency expected 1 got %0d",
                                $time, waited));
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic check_vdp_strobes(input byte_addr_t a, input logic we);
        logic [5:0] mask;
        mask = expected_strobes(a, we);
        check_strobe(mask, strobes, "video-chip strobes after access");
        repeat (3) begin
            @(negedge CLK96);
            check_strobe(mask, strobes, "video-chip strobes while vdp_ack low");
        end
        vdp_ack = 1'b1;
        @(negedge CLK96);
        vdp_ack = 1'b0;
        check_strobe(6'b0, strobes, "video-chip strobes after vdp_ack");
    endtask

    task automatic check_latch(input sound_byte_t value);
        repeat (3) @(negedge CLK96);
        check_byte(value, sound_latch, "sound latch");
        if (latch_pulses != 1)
            abort_run($sformatf("error: at %0d ns: sound_int cycles expected 1 got %0d",
                                $time, latch_pulses));
    endtask

    task automatic after_access(input byte_addr_t a, input logic we, input cpu_word_t d);
        if (is_vdp(a)) begin
            check_vdp_strobes(a, we);
        end else begin
            check_strobe(6'b0, strobes, "strobes after other access");
            if (we && is_latch(a)) check_latch(d[7:0]);
        end
    endtask

    task automatic set_line_count(input logic above);
        logic [31:0] r;
        r = next_rand();
        vcount = {above, r[23:16]};
        hsync = r[24];
        vsync = r[25];
        fblank = r[26];
    endtask

    task automatic video_read(input byte_addr_t a, input cpu_word_t expected);
        byte_addr_t off;
        if (a >= TEXT_BASE) begin
            off = a - TEXT_BASE;
            text_vaddr = off[TEXT_ADDR_W:1];
            @(negedge CLK96);
            check_word(expected, text_vdata, "text video port");
        end else begin
            off = a - PALETTE_BASE;
            pal_vaddr = off[PAL_ADDR_W:1];
            @(negedge CLK96);
            check_word(expected, pal_vdata, "palette video port");
        end
    endtask

    task automatic sound_side(input byte_addr_t a, input logic wr, input cpu_word_t d,
                              input cpu_word_t expected);
        byte_addr_t off;
        off = a - SOUND_RAM_BASE;
        snd_addr = off[SOUND_ADDR_W:1];
        if (wr) begin
            snd_din = d[7:0];
            snd_we = 1'b1;
            @(negedge CLK96);
            snd_we = 1'b0;
        end else begin
            @(negedge CLK96);
            check_byte(expected[7:0], snd_dout, "sound side read");
        end
    endtask

    task automatic run_case(input int i);
        string op;
        byte_addr_t a;
        cpu_word_t d;
        cpu_word_t got;
        op = case_op[i];
        a = case_addr[i];
        d = case_data[i];
        if (op == "W") begin
            latch_pulses = 0;
            bus_access(1'b1, a, case_sel[i], d, got);
            after_access(a, 1'b1, d);
        end else if (op == "R") begin
            bus_access(1'b0, a, case_sel[i], d, got);
            check_word(case_exp[i], got, $sformatf("bus read at %h", a));
            after_access(a, 1'b0, d);
        end else if (op == "P") begin
            if (a == IO_BASE + PORT_VCOUNT) set_line_count(d[0]);
            bus_access(1'b0, a, case_sel[i], d, got);
            check_word(port_value(a), got, $sformatf("port read at %h", a));
            after_access(a, 1'b0, d);
        end else if (op == "V") begin
            video_read(a, case_exp[i]);
        end else if (op == "S") begin
            sound_side(a, case_sel[i][0], d, case_exp[i]);
        end else begin
            abort_run({"unknown operation in cases file: ", op});
        end
    endtask

    initial begin
        wait (cases_ready);
        #((RESET_CYCLES + 20 * case_count) * CLK_PERIOD);
        abort_run("watchdog expired before all cases finished");
    end

    initial begin
        RESET96 = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_sel = '0;
        wb_dat_w = '0;
        pal_vaddr = '0;
        text_vaddr = '0;
        snd_addr = '0;
        snd_din = '0;
        snd_we = 1'b0;
        hsync = 1'b0;
        vsync = 1'b0;
        fblank = 1'b0;
        vdp_ack = 1'b0;
        draw_inputs();
        load_cases();
        repeat (RESET_CYCLES) @(negedge CLK96);
        check_strobe(6'b0, strobes, "strobes in reset");
        if (wb_ack !== 1'b0 || sound_int !== 1'b0)
            abort_run("ack or sound_int is not low during reset");
        RESET96 = 1'b0;
        for (int i = 0; i < case_count; i++) begin
            run_case(i);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/bus_cases.txt ====
# op addr(byte, hex) sel data expected; P computes its own expected value
# W write, R read, P port read, V video port read, S sound side (sel 1 writes)
W 400010 3 1234 0000
W 400010 1 00AB 0000
R 400010 3 0000 12AB
W 400010 2 CD00 0000
R 400010 3 0000 CDAB
V 400010 0 0000 CDAB
W 500100 3 BEEF 0000
W 500100 2 1100 0000
R 500100 3 0000 11EF
V 500100 0 0000 11EF
W 218020 1 0055 0000
S 218020 0 0000 0055
W 218024 3 9966 0000
R 218024 3 0000 0066
S 218040 1 00A7 0000
R 218040 3 0000 00A7
W 218040 2 FF00 0000
R 218040 3 0000 00A7
P 21C020 3 0000 0000
P 21C024 3 0000 0000
P 21C028 3 0000 0000
P 21C02C 3 0000 0000
P 21C030 3 0000 0000
P 21C03C 3 0000 0000
P 21C03C 3 0001 0000
P 21C010 3 0000 0000
P 700000 3 0000 0000
W 600000 1 00C3 0000
W 300000 3 0000 0000
W 300004 3 1111 0000
W 300006 3 2222 0000
W 300008 3 0005 0000
W 30000C 3 0081 0000
P 300004 3 0000 0000
P 300006 3 0000 0000
P 300000 3 0000 0000

// ==== compile.f ====
src/cpu_bus_pkg.sv
src/cpu_bus_if.sv
src/main_bus_decoder.sv
src/video_dual_ram.sv
src/sound_shared_ram.sv
src/io_ports.sv
src/cpu_bus_top.sv
tests/tb_cpu_bus.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_bus
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
